// ==== Makefile ====
# Verilator flow for the ADC scan controller testbench

TOP = adc_scan_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f adc_scan.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

lint:
	verilator --lint-only --timescale 1ns/1ps +incdir+logic \
		logic/adc_scan_pkg.sv logic/apb_regs.sv logic/convst_pacer.sv \
		logic/scan_sequencer.sv logic/spi_master.sv logic/adc_scan_top.sv \
		--top-module adc_scan_top

clean:
	rm -rf obj_dir

// ==== adc_scan.f ====
+incdir+logic
logic/adc_scan_pkg.sv
logic/apb_regs.sv
logic/convst_pacer.sv
logic/scan_sequencer.sv
logic/spi_master.sv
logic/adc_scan_top.sv
test/adc_model.sv
test/adc_scan_properties.sv
test/adc_scan_tb.sv

// ==== logic/adc_scan_config.svh ====
// register map, SPI clock divider, delay reset value and CNVST pulse length
// for the ADC scan controller
`ifndef ADC_SCAN_CONFIG_SVH
`define ADC_SCAN_CONFIG_SVH

// CLK_66 cycles per SCLK half period
`define ADC_SCAN_SPI_DIV 4

// delay register value out of reset
`define ADC_SCAN_DELAY_RESET 16'h0040

// CNVST low time in CLK_66 cycles
`define ADC_SCAN_CNVST_CYCLES 2

// --------------------
// APB byte offsets
// buffer occupies four words from 0x10
`define ADC_SCAN_ADDR_SETUP  8'h00
`define ADC_SCAN_ADDR_DELAY  8'h04
`define ADC_SCAN_ADDR_CTRL   8'h08
`define ADC_SCAN_ADDR_STATUS 8'h0C
`define ADC_SCAN_ADDR_BUF    8'h10

`endif

// ==== logic/adc_scan_pkg.sv ====
// data types and state encodings shared by the ADC scan controller
package adc_scan_pkg;

	// --------------------
	// data types
	typedef logic [7:0]  byte_t;
	typedef logic [9:0]  sample_t;
	typedef logic [1:0]  chan_t;
	typedef logic [15:0] delay_t;
	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// --------------------
	// state machines
	// literals carry a prefix since all enums share the package scope
	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_SEND_SETUP,
		SEQ_WAIT_EOC,
		SEQ_READ_MSB,
		SEQ_READ_LSB,
		SEQ_STORE,
		SEQ_SCAN_DONE
	} seq_state_e;

	typedef enum logic [1:0] {PACE_STOPPED, PACE_COUNT, PACE_PULSE, PACE_WAIT_SCAN} pacer_state_e;

	typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_FINISH} spi_state_e;

endpackage

// ==== logic/adc_scan_top.sv ====
// top level of the ADC scan controller
// APB register block, conversion pacer, scan sequencer and SPI master
`timescale 1ns/1ps

module adc_scan_top (
	input  logic                    CLK_66,
	input  logic                    RST,
	// APB slave
	input  adc_scan_pkg::apb_addr_t paddr,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  adc_scan_pkg::apb_data_t pwdata,
	output adc_scan_pkg::apb_data_t prdata,
	output logic                    pready,
	output logic                    pslverr,
	// ADC pins
	output logic                    adc_mosi,
	output logic                    adc_sclk,
	input  logic                    adc_miso,
	output logic                    adc_cs_n,
	output logic                    adc_cnvst_n,
	input  logic                    adc_eoc_n
);

	// --------------------
	// register block to sequencer and pacer
	logic                        setup_req;
	logic                        setup_ack;
	adc_scan_pkg::byte_t         setup_byte;
	adc_scan_pkg::chan_t         last_chan;
	logic                        run;
	adc_scan_pkg::delay_t        delay;

	// sample path back into the buffer
	logic                        sample_valid;
	adc_scan_pkg::chan_t         sample_chan;
	adc_scan_pkg::sample_t       sample;
	logic                        scan_done;
	logic                        conv_start;

	// byte handshake with the SPI master
	logic                        spi_start;
	adc_scan_pkg::byte_t         spi_tx;
	logic                        spi_done;
	adc_scan_pkg::byte_t         spi_rx;
	logic                        spi_busy;

	apb_regs regs_i (.CLK_66, .RST, .paddr, .psel, .penable, .pwrite, .pwdata,
		.setup_ack, .sample_valid, .sample_chan, .sample, .scan_done, .spi_busy,
		.prdata, .pready, .pslverr, .setup_req, .setup_byte, .last_chan, .run, .delay);

	convst_pacer pacer_i (.CLK_66, .RST, .run, .delay, .scan_done, .adc_cnvst_n, .conv_start);

	scan_sequencer seq_i (.CLK_66, .RST, .setup_req, .setup_byte, .last_chan, .conv_start,
		.adc_eoc_n, .spi_done, .spi_rx, .setup_ack, .spi_start, .spi_tx, .sample_valid,
		.sample_chan, .sample, .scan_done);

	spi_master spi_i (.CLK_66, .RST, .spi_start, .spi_tx, .adc_miso, .spi_done, .spi_rx,
		.spi_busy, .adc_sclk, .adc_mosi, .adc_cs_n);

endmodule

// ==== logic/apb_regs.sv ====
// APB slave with setup, delay, control and status registers
// plus the four-word sample buffer
`timescale 1ns/1ps
`include "adc_scan_config.svh"

module apb_regs (
	input  logic                    CLK_66,
	input  logic                    RST,
	input  adc_scan_pkg::apb_addr_t paddr,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  adc_scan_pkg::apb_data_t pwdata,
	input  logic                    setup_ack,
	input  logic                    sample_valid,
	input  adc_scan_pkg::chan_t     sample_chan,
	input  adc_scan_pkg::sample_t   sample,
	input  logic                    scan_done,
	input  logic                    spi_busy,
	output adc_scan_pkg::apb_data_t prdata,
	output logic                    pready,
	output logic                    pslverr,
	output logic                    setup_req,
	output adc_scan_pkg::byte_t     setup_byte,
	output adc_scan_pkg::chan_t     last_chan,
	output logic                    run,
	output adc_scan_pkg::delay_t    delay
);

	logic                  access;
	logic                  buf_hit;
	logic                  ro_hit;
	logic                  in_map;
	logic                  wr_en;
	logic [7:0]            frame_cnt;
	adc_scan_pkg::sample_t sample_buf [4];

	// --------------------
	// address decode
	assign access  = psel && penable;
	assign buf_hit = ((paddr & 8'hF0) == `ADC_SCAN_ADDR_BUF) && (paddr[1:0] == 2'b00);
	assign ro_hit  = buf_hit || (paddr == `ADC_SCAN_ADDR_STATUS);
	assign in_map  = ro_hit || (paddr == `ADC_SCAN_ADDR_SETUP) ||
		(paddr == `ADC_SCAN_ADDR_DELAY) || (paddr == `ADC_SCAN_ADDR_CTRL);

	// no wait states, error on unmapped or read-only target
	assign pready  = 1'b1;
	assign pslverr = access && (!in_map || (pwrite && ro_hit));
	assign wr_en   = access && pwrite && !pslverr;

	// --------------------
	// register writes
	always_ff @(posedge CLK_66 or negedge RST)
	begin
		if (!RST)
		begin
			setup_req  <= 1'b0;
			setup_byte <= '0;
			last_chan  <= '0;
			run        <= 1'b0;
			delay      <= `ADC_SCAN_DELAY_RESET;
		end
		else
		begin
			// new write wins over the ack of an older byte
			if (wr_en && (paddr == `ADC_SCAN_ADDR_SETUP))
			begin
				setup_byte <= pwdata[7:0];
				setup_req  <= 1'b1;
				// bit 7 selects a scan, bits 4:3 give its last channel
				if (pwdata[7])
					last_chan <= pwdata[4:3];
			end
			else if (setup_ack)
				setup_req <= 1'b0;
			if (wr_en && (paddr == `ADC_SCAN_ADDR_DELAY))
				delay <= pwdata[15:0];
			// stop bit overrides start
			if (wr_en && (paddr == `ADC_SCAN_ADDR_CTRL))
			begin
				if (pwdata[1])
					run <= 1'b0;
				else if (pwdata[0])
					run <= 1'b1;
			end
		end
	end

	// frame counter and sample buffer
	always_ff @(posedge CLK_66 or negedge RST)
	begin
		if (!RST)
		begin
			frame_cnt <= '0;
			for (int i = 0; i < 4; i++)
				sample_buf[i] <= '0;
		end
		else
		begin
			if (scan_done)
				frame_cnt <= frame_cnt + 8'd1;
			if (sample_valid)
				sample_buf[sample_chan] <= sample;
		end
	end

	// --------------------
	// read mux, only during a read access
	always_comb
	begin
		prdata = '0;
		if (access && !pwrite)
		begin
			if (buf_hit)
				prdata = {22'd0, sample_buf[paddr[3:2]]};
			else if (paddr == `ADC_SCAN_ADDR_SETUP)
				prdata = {24'd0, setup_byte};
			else if (paddr == `ADC_SCAN_ADDR_DELAY)
				prdata = {16'd0, delay};
			else if (paddr == `ADC_SCAN_ADDR_CTRL)
				prdata = {31'd0, run};
			else if (paddr == `ADC_SCAN_ADDR_STATUS)
				prdata = {16'd0, frame_cnt, 5'd0, setup_req, spi_busy, run};
		end
	end

endmodule

// ==== logic/convst_pacer.sv ====
// conversion pacer: delay counter and two-cycle CNVST pulse
`timescale 1ns/1ps
`include "adc_scan_config.svh"

module convst_pacer (
	input  logic                 CLK_66,
	input  logic                 RST,
	input  logic                 run,
	input  adc_scan_pkg::delay_t delay,
	input  logic                 scan_done,
	output logic                 adc_cnvst_n,
	output logic                 conv_start
);

	adc_scan_pkg::pacer_state_e state;
	adc_scan_pkg::delay_t       delay_cnt;
	logic [3:0]                 pulse_cnt;

	always_ff @(posedge CLK_66 or negedge RST)
	begin
		if (!RST)
		begin
			state       <= adc_scan_pkg::PACE_STOPPED;
			delay_cnt   <= '0;
			pulse_cnt   <= '0;
			adc_cnvst_n <= 1'b1;
			conv_start  <= 1'b0;
		end
		else
		begin
			conv_start <= 1'b0;
			case (state)
				adc_scan_pkg::PACE_STOPPED:
				begin
					adc_cnvst_n <= 1'b1;
					delay_cnt   <= '0;
					if (run)
						state <= adc_scan_pkg::PACE_COUNT;
				end
				// stop drops the count right away
				adc_scan_pkg::PACE_COUNT:
				begin
					if (!run)
						state <= adc_scan_pkg::PACE_STOPPED;
					else if (delay_cnt == delay)
					begin
						// CNVST low and start strobe on the same edge
						adc_cnvst_n <= 1'b0;
						conv_start  <= 1'b1;
						pulse_cnt   <= '0;
						state       <= adc_scan_pkg::PACE_PULSE;
					end
					else
						delay_cnt <= delay_cnt + 16'd1;
				end
				// pulse always runs its full length once started
				adc_scan_pkg::PACE_PULSE:
				begin
					pulse_cnt <= pulse_cnt + 4'd1;
					if (pulse_cnt == 4'(`ADC_SCAN_CNVST_CYCLES - 1))
					begin
						adc_cnvst_n <= 1'b1;
						state       <= adc_scan_pkg::PACE_WAIT_SCAN;
					end
				end
				// hold off until the sequencer has read every channel
				default:
				begin
					delay_cnt <= '0;
					if (scan_done)
						state <= run ? adc_scan_pkg::PACE_COUNT : adc_scan_pkg::PACE_STOPPED;
				end
			endcase
		end
	end

endmodule

// ==== logic/scan_sequencer.sv ====
// scan sequencer: setup byte transfer, EOC wait, channel byte pair reads
// and 10-bit sample assembly
`timescale 1ns/1ps

module scan_sequencer (
	input  logic                  CLK_66,
	input  logic                  RST,
	input  logic                  setup_req,
	input  adc_scan_pkg::byte_t   setup_byte,
	input  adc_scan_pkg::chan_t   last_chan,
	input  logic                  conv_start,
	input  logic                  adc_eoc_n,
	input  logic                  spi_done,
	input  adc_scan_pkg::byte_t   spi_rx,
	output logic                  setup_ack,
	output logic                  spi_start,
	output adc_scan_pkg::byte_t   spi_tx,
	output logic                  sample_valid,
	output adc_scan_pkg::chan_t   sample_chan,
	output adc_scan_pkg::sample_t sample,
	output logic                  scan_done
);

	adc_scan_pkg::seq_state_e state;
	logic                     eoc_q;
	logic                     conv_pend;
	adc_scan_pkg::chan_t      chan;
	adc_scan_pkg::chan_t      last_q;
	logic [3:0]               msb_q;

	// --------------------
	// single EOC register stage
	always_ff @(posedge CLK_66 or negedge RST)
	begin
		if (!RST)
			eoc_q <= 1'b1;
		else
			eoc_q <= adc_eoc_n;
	end

	// --------------------
	// payload, updated on handshakes only
	always_ff @(posedge CLK_66)
	begin
		if (state == adc_scan_pkg::SEQ_IDLE)
			spi_tx <= setup_byte;
		else
			spi_tx <= 8'h00;
		if ((state == adc_scan_pkg::SEQ_READ_MSB) && spi_done)
			msb_q <= spi_rx[3:0];
		// low nibble of first byte, then top six bits of second
		if ((state == adc_scan_pkg::SEQ_READ_LSB) && spi_done)
			sample <= {msb_q, spi_rx[7:2]};
	end

	// --------------------
	// main FSM
	always_ff @(posedge CLK_66 or negedge RST)
	begin
		if (!RST)
		begin
			state        <= adc_scan_pkg::SEQ_IDLE;
			conv_pend    <= 1'b0;
			chan         <= '0;
			last_q       <= '0;
			sample_chan  <= '0;
			setup_ack    <= 1'b0;
			spi_start    <= 1'b0;
			sample_valid <= 1'b0;
			scan_done    <= 1'b0;
		end
		else
		begin
			setup_ack    <= 1'b0;
			spi_start    <= 1'b0;
			sample_valid <= 1'b0;
			scan_done    <= 1'b0;
			// hold a conversion start that lands during a setup transfer
			if (conv_start)
				conv_pend <= 1'b1;
			case (state)
				adc_scan_pkg::SEQ_IDLE:
				begin
					// skip the ack cycle, req is still high there
					if (setup_req && !setup_ack)
					begin
						spi_start <= 1'b1;
						state     <= adc_scan_pkg::SEQ_SEND_SETUP;
					end
					else if (conv_start || conv_pend)
					begin
						conv_pend <= 1'b0;
						last_q    <= last_chan;
						chan      <= '0;
						state     <= adc_scan_pkg::SEQ_WAIT_EOC;
					end
				end
				adc_scan_pkg::SEQ_SEND_SETUP:
				begin
					if (spi_done)
					begin
						setup_ack <= 1'b1;
						state     <= adc_scan_pkg::SEQ_IDLE;
					end
				end
				adc_scan_pkg::SEQ_WAIT_EOC:
				begin
					if (!eoc_q)
					begin
						spi_start <= 1'b1;
						state     <= adc_scan_pkg::SEQ_READ_MSB;
					end
				end
				adc_scan_pkg::SEQ_READ_MSB:
				begin
					if (spi_done)
					begin
						spi_start <= 1'b1;
						state     <= adc_scan_pkg::SEQ_READ_LSB;
					end
				end
				adc_scan_pkg::SEQ_READ_LSB:
				begin
					if (spi_done)
					begin
						sample_valid <= 1'b1;
						sample_chan  <= chan;
						state        <= adc_scan_pkg::SEQ_STORE;
					end
				end
				// next channel or end of scan
				adc_scan_pkg::SEQ_STORE:
				begin
					if (chan == last_q)
					begin
						scan_done <= 1'b1;
						state     <= adc_scan_pkg::SEQ_SCAN_DONE;
					end
					else
					begin
						chan      <= chan + 2'd1;
						spi_start <= 1'b1;
						state     <= adc_scan_pkg::SEQ_READ_MSB;
					end
				end
				default:
					state <= adc_scan_pkg::SEQ_IDLE;
			endcase
		end
	end

endmodule

// ==== logic/spi_master.sv ====
// mode-0 SPI master, one byte per request with chip select framing
`timescale 1ns/1ps
`include "adc_scan_config.svh"

module spi_master (
	input  logic                CLK_66,
	input  logic                RST,
	input  logic                spi_start,
	input  adc_scan_pkg::byte_t spi_tx,
	input  logic                adc_miso,
	output logic                spi_done,
	output adc_scan_pkg::byte_t spi_rx,
	output logic                spi_busy,
	output logic                adc_sclk,
	output logic                adc_mosi,
	output logic                adc_cs_n
);

	adc_scan_pkg::spi_state_e state;
	adc_scan_pkg::byte_t      tx_shift;
	logic [7:0]               div_cnt;
	logic [2:0]               bit_cnt;

	// MSB first straight off the shift register
	assign adc_mosi = tx_shift[7];
	assign spi_busy = (state != adc_scan_pkg::SPI_IDLE);

	// receive shifter, sampled on rising SCLK
	always_ff @(posedge CLK_66)
	begin
		if ((state == adc_scan_pkg::SPI_SHIFT) && !adc_sclk &&
			(div_cnt == 8'(`ADC_SCAN_SPI_DIV - 1)))
			spi_rx <= {spi_rx[6:0], adc_miso};
	end

	always_ff @(posedge CLK_66 or negedge RST)
	begin
		if (!RST)
		begin
			state    <= adc_scan_pkg::SPI_IDLE;
			tx_shift <= '0;
			div_cnt  <= '0;
			bit_cnt  <= '0;
			adc_sclk <= 1'b0;
			adc_cs_n <= 1'b1;
			spi_done <= 1'b0;
		end
		else
		begin
			spi_done <= 1'b0;
			case (state)
				adc_scan_pkg::SPI_IDLE:
				begin
					if (spi_start)
					begin
						// CS low one cycle after the request
						tx_shift <= spi_tx;
						div_cnt  <= '0;
						bit_cnt  <= '0;
						adc_sclk <= 1'b0;
						adc_cs_n <= 1'b0;
						state    <= adc_scan_pkg::SPI_SHIFT;
					end
				end
				adc_scan_pkg::SPI_SHIFT:
				begin
					if (div_cnt == 8'(`ADC_SCAN_SPI_DIV - 1))
					begin
						div_cnt  <= '0;
						adc_sclk <= !adc_sclk;
						// falling edge moves MOSI to the next bit
						if (adc_sclk)
						begin
							if (bit_cnt == 3'd7)
								state <= adc_scan_pkg::SPI_FINISH;
							else
							begin
								bit_cnt  <= bit_cnt + 3'd1;
								tx_shift <= {tx_shift[6:0], 1'b0};
							end
						end
					end
					else
						div_cnt <= div_cnt + 8'd1;
				end
				// CS release and done strobe together
				default:
				begin
					adc_cs_n <= 1'b1;
					spi_done <= 1'b1;
					state    <= adc_scan_pkg::SPI_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== test/adc_model.sv ====
// behavioral MAX11618-style ADC: setup byte capture, EOC after CNVST,
// sample byte pairs drawn from a Galois LFSR
`timescale 1ns/1ps

module adc_model (
	input  logic CLK_66,
	input  logic adc_mosi,
	input  logic adc_sclk,
	input  logic adc_cs_n,
	input  logic adc_cnvst_n,
	output logic adc_miso,
	output logic adc_eoc_n
);

	// every byte seen on MOSI, setup and read dummies alike
	adc_scan_pkg::byte_t   rx_bytes [$];
	// last value handed out per channel
	adc_scan_pkg::sample_t vals [4] = '{default: '0};

	logic                  eoc_n = 1'b1;
	int                    conv_cnt = 0;
	int                    conv_seen = 0;
	logic                  scanning = 1'b0;
	logic [3:0]            byte_idx = '0;
	adc_scan_pkg::chan_t   last_chan = '0;
	adc_scan_pkg::byte_t   miso_sh = '0;
	adc_scan_pkg::byte_t   rx_sh = '0;
	logic [15:0]           lfsr = 16'd20771;
	adc_scan_pkg::sample_t cur_val = '0;

	assign adc_miso  = miso_sh[7];
	assign adc_eoc_n = eoc_n;

	// x^16 + x^14 + x^13 + x^11 + 1, shifting right
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// --------------------
	// conversion: EOC low two clocks after CNVST falls, released by next CS fall
	always
	begin
		@(negedge adc_cnvst_n);
		conv_cnt = conv_cnt + 1;
		repeat (2) @(posedge CLK_66);
		eoc_n <= 1'b0;
		@(negedge adc_cs_n);
		eoc_n <= 1'b1;
	end

	// --------------------
	// one byte per CS frame, mode 0
	always
	begin
		@(negedge adc_cs_n);
		// first frame after a conversion opens a scan
		if (conv_cnt != conv_seen)
		begin
			conv_seen = conv_cnt;
			scanning  = 1'b1;
			byte_idx  = '0;
		end
		if (scanning && !byte_idx[0])
		begin
			// fresh value, one LFSR step per bit
			for (int k = 0; k < 10; k++)
			begin
				cur_val = {cur_val[8:0], lfsr[0]};
				lfsr    = lfsr_step(lfsr);
			end
			vals[byte_idx[2:1]] = cur_val;
			miso_sh = {4'h0, cur_val[9:6]};
		end
		else if (scanning)
			miso_sh = {cur_val[5:0], 2'b00};
		else
			miso_sh = 8'h00;
		for (int n = 0; n < 8; n++)
		begin
			@(posedge adc_sclk);
			rx_sh = {rx_sh[6:0], adc_mosi};
			@(negedge adc_sclk);
			miso_sh = {miso_sh[6:0], 1'b0};
		end
		@(posedge adc_cs_n);
		rx_bytes.push_back(rx_sh);
		if (scanning)
		begin
			byte_idx = byte_idx + 4'd1;
			// two bytes per channel up to the programmed last channel
			if (byte_idx[3:1] == {1'b0, last_chan} + 3'd1)
				scanning = 1'b0;
		end
		else if (rx_sh[7])
			last_chan = rx_sh[4:3];
	end

endmodule

// ==== test/adc_scan_properties.sv ====
// assertions on the CNVST pulse, SPI chip select and APB error response
`timescale 1ns/1ps

module adc_scan_properties (
	input logic CLK_66,
	input logic RST,
	input logic adc_cnvst_n,
	input logic adc_cs_n,
	input logic spi_busy,
	input logic psel,
	input logic penable,
	input logic pslverr
);

	// low for two sampled clocks, then back high
	cnvst_two_cycles: assert property (@(posedge CLK_66) disable iff (!RST)
		$fell(adc_cnvst_n) |=> !adc_cnvst_n ##1 adc_cnvst_n)
		else $error("CNVST low pulse is not two cycles long");

	// idle SPI master keeps the ADC deselected
	cs_high_when_idle: assert property (@(posedge CLK_66) disable iff (!RST)
		!spi_busy |-> adc_cs_n)
		else $error("chip select low while the SPI master is idle");

	pslverr_in_access: assert property (@(posedge CLK_66) disable iff (!RST)
		pslverr |-> (psel && penable))
		else $error("pslverr raised outside an APB access phase");

endmodule

// ==== test/adc_scan_tb.sv ====
// ADC scan controller testbench with APB tasks, compare tasks,
// directed tests and the closing result
`timescale 1ns/1ps
`include "adc_scan_config.svh"

module adc_scan_tb;

	// poll and wait limits
	localparam int FRAME_POLLS  = 2000;
	localparam int SETUP_POLLS  = 200;
	localparam int CS_CYCLES    = 4000;
	localparam int QUIET_CYCLES = 1500;

	logic                    CLK_66;
	logic                    RST;
	adc_scan_pkg::apb_addr_t paddr;
	logic                    psel;
	logic                    penable;
	logic                    pwrite;
	adc_scan_pkg::apb_data_t pwdata;
	adc_scan_pkg::apb_data_t prdata;
	logic                    pready;
	logic                    pslverr;
	logic                    adc_mosi;
	logic                    adc_sclk;
	logic                    adc_miso;
	logic                    adc_cs_n;
	logic                    adc_cnvst_n;
	logic                    adc_eoc_n;

	int                      mismatch_cnt;
	int                      fail_cnt;
	adc_scan_pkg::sample_t   prev_vals [4];

	adc_scan_top dut_i (.CLK_66, .RST, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
		.pready, .pslverr, .adc_mosi, .adc_sclk, .adc_miso, .adc_cs_n, .adc_cnvst_n,
		.adc_eoc_n);

	adc_model adc_i (.CLK_66, .adc_mosi, .adc_sclk, .adc_cs_n, .adc_cnvst_n, .adc_miso,
		.adc_eoc_n);

	bind adc_scan_top adc_scan_properties props_i (.CLK_66(CLK_66), .RST(RST),
		.adc_cnvst_n(adc_cnvst_n), .adc_cs_n(adc_cs_n), .spi_busy(spi_busy),
		.psel(psel), .penable(penable), .pslverr(pslverr));

	// 20 ns period
	always #10 CLK_66 = ~CLK_66;

	// --------------------
	// compare tasks
	task automatic check_sample(input string name, input adc_scan_pkg::sample_t got,
		input adc_scan_pkg::sample_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
			mismatch_cnt++;
		end
	endtask

	task automatic check_byte(input string name, input adc_scan_pkg::byte_t got,
		input adc_scan_pkg::byte_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
			mismatch_cnt++;
		end
	endtask

	task automatic check_delay(input string name, input adc_scan_pkg::delay_t got,
		input adc_scan_pkg::delay_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
			mismatch_cnt++;
		end
	endtask

	task automatic check_word(input string name, input adc_scan_pkg::apb_data_t got,
		input adc_scan_pkg::apb_data_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
			mismatch_cnt++;
		end
	endtask

	// --------------------
	// APB access, driven on falling edges
	task automatic apb_write(input adc_scan_pkg::apb_addr_t addr,
		input adc_scan_pkg::apb_data_t data, input logic expect_err);
		@(negedge CLK_66);
		paddr   = addr;
		pwdata  = data;
		pwrite  = 1'b1;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge CLK_66);
		penable = 1'b1;
		// mid access phase clear of the clock edge
		#1;
		check_word($sformatf("pready wr %h", addr), {31'd0, pready}, 32'd1);
		check_word($sformatf("pslverr wr %h", addr), {31'd0, pslverr}, {31'd0, expect_err});
		@(negedge CLK_66);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input adc_scan_pkg::apb_addr_t addr,
		output adc_scan_pkg::apb_data_t data, input logic expect_err);
		@(negedge CLK_66);
		paddr   = addr;
		pwrite  = 1'b0;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge CLK_66);
		penable = 1'b1;
		#1;
		data = prdata;
		check_word($sformatf("pready rd %h", addr), {31'd0, pready}, 32'd1);
		check_word($sformatf("pslverr rd %h", addr), {31'd0, pslverr}, {31'd0, expect_err});
		@(negedge CLK_66);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// --------------------
	// bounded waits
	task automatic wait_frames(input logic [7:0] target);
		adc_scan_pkg::apb_data_t st;
		int polls;
		polls = 0;
		apb_read(`ADC_SCAN_ADDR_STATUS, st, 1'b0);
		while ((st[15:8] < target) && (polls < FRAME_POLLS))
		begin
			apb_read(`ADC_SCAN_ADDR_STATUS, st, 1'b0);
			polls++;
		end
		if (st[15:8] < target)
		begin
			$display("timeout at %0t: frame counter at %0d never reached %0d",
				$time, st[15:8], target);
			fail_cnt++;
		end
	endtask

	task automatic wait_setup_done();
		adc_scan_pkg::apb_data_t st;
		int polls;
		polls = 0;
		apb_read(`ADC_SCAN_ADDR_STATUS, st, 1'b0);
		while (st[2] && (polls < SETUP_POLLS))
		begin
			apb_read(`ADC_SCAN_ADDR_STATUS, st, 1'b0);
			polls++;
		end
		if (st[2])
		begin
			$display("timeout at %0t: setup request never cleared", $time);
			fail_cnt++;
		end
	endtask

	task automatic wait_cs_low();
		int cycles;
		cycles = 0;
		while (adc_cs_n && (cycles < CS_CYCLES))
		begin
			@(negedge CLK_66);
			cycles++;
		end
		if (adc_cs_n)
		begin
			$display("timeout at %0t: chip select never went low", $time);
			fail_cnt++;
		end
	endtask

	task automatic check_buffer(input adc_scan_pkg::chan_t ch,
		input adc_scan_pkg::sample_t exp);
		adc_scan_pkg::apb_data_t rd;
		apb_read(`ADC_SCAN_ADDR_BUF + {4'd0, ch, 2'b00}, rd, 1'b0);
		check_sample($sformatf("buffer word %0d", ch), rd[9:0], exp);
	endtask

	// --------------------
	// directed tests
	task automatic test_reset_values();
		adc_scan_pkg::apb_data_t rd;
		apb_read(`ADC_SCAN_ADDR_DELAY, rd, 1'b0);
		check_delay("delay after reset", rd[15:0], `ADC_SCAN_DELAY_RESET);
		apb_read(`ADC_SCAN_ADDR_STATUS, rd, 1'b0);
		check_word("status after reset", rd, 32'd0);
		for (int i = 0; i < 4; i++)
			check_buffer(2'(i), '0);
		check_word("adc_cnvst_n", {31'd0, adc_cnvst_n}, 32'd1);
		check_word("adc_cs_n", {31'd0, adc_cs_n}, 32'd1);
	endtask

	task automatic test_setup_transfer();
		adc_scan_pkg::apb_data_t rd;
		int base;
		base = adc_i.rx_bytes.size();
		// bit 7 clear so the scan length stays
		apb_write(`ADC_SCAN_ADDR_SETUP, 32'h5A, 1'b0);
		wait_setup_done();
		if (adc_i.rx_bytes.size() != base + 1)
		begin
			$display("setup write sent %0d bytes to the ADC instead of one",
				adc_i.rx_bytes.size() - base);
			fail_cnt++;
		end
		else
			check_byte("ADC setup byte", adc_i.rx_bytes[$], 8'h5A);
		apb_read(`ADC_SCAN_ADDR_SETUP, rd, 1'b0);
		check_byte("setup register", rd[7:0], 8'h5A);
		// shorter delay for the scan tests
		apb_write(`ADC_SCAN_ADDR_DELAY, 32'h0020, 1'b0);
		apb_read(`ADC_SCAN_ADDR_DELAY, rd, 1'b0);
		check_delay("delay readback", rd[15:0], 16'h0020);
	endtask

	task automatic test_four_channel_scan();
		adc_scan_pkg::apb_data_t rd;
		// scan enable with last channel 3
		apb_write(`ADC_SCAN_ADDR_SETUP, 32'h98, 1'b0);
		wait_setup_done();
		check_byte("ADC setup byte", adc_i.rx_bytes[$], 8'h98);
		apb_write(`ADC_SCAN_ADDR_CTRL, 32'h1, 1'b0);
		wait_frames(8'd1);
		apb_write(`ADC_SCAN_ADDR_CTRL, 32'h2, 1'b0);
		apb_read(`ADC_SCAN_ADDR_STATUS, rd, 1'b0);
		check_word("status after four-channel scan", rd, 32'h0000_0100);
		for (int i = 0; i < 4; i++)
		begin
			check_buffer(2'(i), adc_i.vals[2'(i)]);
			prev_vals[2'(i)] = adc_i.vals[2'(i)];
		end
	endtask

	task automatic test_one_channel_scan();
		adc_scan_pkg::apb_data_t rd;
		apb_write(`ADC_SCAN_ADDR_SETUP, 32'h80, 1'b0);
		wait_setup_done();
		apb_write(`ADC_SCAN_ADDR_CTRL, 32'h1, 1'b0);
		wait_frames(8'd2);
		apb_write(`ADC_SCAN_ADDR_CTRL, 32'h2, 1'b0);
		apb_read(`ADC_SCAN_ADDR_STATUS, rd, 1'b0);
		check_word("status after one-channel scan", rd, 32'h0000_0200);
		check_buffer(2'd0, adc_i.vals[0]);
		// upper words still hold the four-channel results
		for (int i = 1; i < 4; i++)
			check_buffer(2'(i), prev_vals[2'(i)]);
	endtask

	task automatic test_stop();
		adc_scan_pkg::apb_data_t rd;
		apb_write(`ADC_SCAN_ADDR_CTRL, 32'h1, 1'b0);
		wait_frames(8'd3);
		// stop while the next scan is on the wire
		wait_cs_low();
		apb_write(`ADC_SCAN_ADDR_CTRL, 32'h2, 1'b0);
		wait_frames(8'd4);
		apb_read(`ADC_SCAN_ADDR_STATUS, rd, 1'b0);
		check_word("status after stop", rd, 32'h0000_0400);
		// longer than delay plus one full scan
		repeat (QUIET_CYCLES) @(negedge CLK_66);
		apb_read(`ADC_SCAN_ADDR_STATUS, rd, 1'b0);
		check_word("status after quiet period", rd, 32'h0000_0400);
		check_word("adc_cnvst_n after stop", {31'd0, adc_cnvst_n}, 32'd1);
	endtask

	task automatic test_bus_errors();
		adc_scan_pkg::apb_data_t setup_snap;
		adc_scan_pkg::apb_data_t delay_snap;
		adc_scan_pkg::apb_data_t status_snap;
		adc_scan_pkg::apb_data_t buf_snap;
		adc_scan_pkg::apb_data_t rd;
		apb_read(`ADC_SCAN_ADDR_SETUP, setup_snap, 1'b0);
		apb_read(`ADC_SCAN_ADDR_DELAY, delay_snap, 1'b0);
		apb_read(`ADC_SCAN_ADDR_STATUS, status_snap, 1'b0);
		apb_read(`ADC_SCAN_ADDR_BUF, buf_snap, 1'b0);
		// unmapped read then writes to read-only words
		apb_read(8'h20, rd, 1'b1);
		apb_write(`ADC_SCAN_ADDR_STATUS, 32'hFFFF_FFFF, 1'b1);
		apb_write(`ADC_SCAN_ADDR_BUF, 32'h0000_0155, 1'b1);
		apb_read(`ADC_SCAN_ADDR_SETUP, rd, 1'b0);
		check_word("setup after bus errors", rd, setup_snap);
		apb_read(`ADC_SCAN_ADDR_DELAY, rd, 1'b0);
		check_word("delay after bus errors", rd, delay_snap);
		apb_read(`ADC_SCAN_ADDR_STATUS, rd, 1'b0);
		check_word("status after bus errors", rd, status_snap);
		apb_read(`ADC_SCAN_ADDR_BUF, rd, 1'b0);
		check_word("buffer word 0 after bus errors", rd, buf_snap);
	endtask

	// --------------------
	// main sequence
	initial
	begin
		CLK_66       = 1'b0;
		RST          = 1'b0;
		paddr        = '0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		pwdata       = '0;
		mismatch_cnt = 0;
		fail_cnt     = 0;
		repeat (3) @(posedge CLK_66);
		@(negedge CLK_66);
		RST = 1'b1;

		test_reset_values();
		test_setup_transfer();
		test_four_channel_scan();
		test_one_channel_scan();
		test_stop();
		test_bus_errors();

		$display("result: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
		if ((mismatch_cnt == 0) && (fail_cnt == 0))
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule
